// File: hw/soc_pkg.sv
package soc_pkg;

  // ------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------
  // Area prefix in address bits 31:30
  localparam logic [1:0] AREA_ROM      = 2'h0;
  localparam logic [1:0] AREA_RAM      = 2'h1;
  localparam logic [1:0] AREA_RESERVED = 2'h2;
  localparam logic [1:0] AREA_MMIO     = 2'h3;

  // Core prefix in address bits 29:24, MMIO area only
  localparam logic [5:0] CORE_TIMER    = 6'h01;
  localparam logic [5:0] CORE_FW_RAM   = 6'h10;
  localparam logic [5:0] CORE_SYS_CTRL = 6'h3f;

  // Word returned on a forced trap
  localparam logic [31:0] ILLEGAL_INSTRUCTION = 32'h0;

  // Memory sizes as word-address widths
  localparam int RAM_ADDR_BITS    = 10;
  localparam int FW_RAM_ADDR_BITS = 8;
  localparam int ROM_ADDR_BITS    = 6;

  // ROM word i holds this xor i
  localparam logic [31:0] ROM_SIGNATURE = 32'h5a17_c0de;

  // Timer register map
  localparam logic [15:0] TMR_CTRL      = 16'h0;
  localparam logic [15:0] TMR_STATUS    = 16'h1;
  localparam logic [15:0] TMR_PRESCALER = 16'h2;
  localparam logic [15:0] TMR_VALUE     = 16'h3;

  // System control register map
  localparam logic [15:0] CTL_APP_MODE = 16'h0;
  localparam logic [15:0] CTL_LED      = 16'h1;
  localparam logic [15:0] CTL_ADDR_KEY = 16'h2;
  localparam logic [15:0] CTL_DATA_KEY = 16'h3;

  localparam logic [2:0] LED_RESET = 3'b000;

  // ------------------------------------------------------------------
  // Bus structs
  // ------------------------------------------------------------------
  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic        cs;
    logic [3:0]  we;
    logic [15:0] address;
    logic [31:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } core_rsp_t;

endpackage

// File: hw/sram_bank.sv
`timescale 1ns/1ns

module sram_bank import soc_pkg::*; #(
  parameter int DEPTH_BITS = RAM_ADDR_BITS
) (
  input  logic      clk,
  input  logic      reset_n,
  input  core_req_t req,
  output core_rsp_t rsp
);

  logic [31:0]           mem [2**DEPTH_BITS];
  logic [DEPTH_BITS-1:0] word_addr;
  logic [31:0]           rdata_reg;
  logic                  ready_reg;

  assign word_addr = req.address[DEPTH_BITS-1:0];

  // Byte-enabled write, read returns the word before the write
  always_ff @(posedge clk) begin
    if (req.cs) begin
      for (int i = 0; i < 4; i++) begin
        if (req.we[i]) begin
          mem[word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
      rdata_reg <= mem[word_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= req.cs;
    end
  end

  assign rsp = '{ready: ready_reg, rdata: rdata_reg};

  // Decoder must trim the address to this bank
  a_addr_fits: assert property (@(posedge clk) disable iff (!reset_n)
    req.cs |-> (req.address >> DEPTH_BITS) == 16'h0);

endmodule

// File: hw/boot_rom.sv
`timescale 1ns/1ns

module boot_rom import soc_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  core_req_t req,
  output core_rsp_t rsp
);

  logic [31:0] rdata_reg;
  logic        ready_reg;

  // Image content for one word index
  function automatic logic [31:0] rom_word(input logic [ROM_ADDR_BITS-1:0] index);
    return ROM_SIGNATURE ^ 32'(index);
  endfunction

  always_ff @(posedge clk) begin
    if (req.cs) begin
      rdata_reg <= rom_word(req.address[ROM_ADDR_BITS-1:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= req.cs;
    end
  end

  assign rsp = '{ready: ready_reg, rdata: rdata_reg};

  // Software never stores into the ROM area
  a_no_write: assert property (@(posedge clk) disable iff (!reset_n)
    req.cs |-> req.we == 4'h0);

endmodule

// File: hw/mmio_timer.sv
`timescale 1ns/1ns

module mmio_timer import soc_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  core_req_t req,
  output core_rsp_t rsp
);

  logic        wr;
  logic        running;
  logic [31:0] prescaler;
  logic [31:0] value;
  logic [31:0] presc_cnt;
  logic [31:0] rdata_reg;
  logic        ready_reg;

  assign wr = req.cs && (|req.we);

  // ------------------------------------------------------------------
  // Counter and register writes
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      running   <= 1'b0;
      prescaler <= 32'h0;
      value     <= 32'h0;
      presc_cnt <= 32'h0;
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= req.cs;

      if (running) begin
        if (value == 32'h0) begin
          running <= 1'b0;
        end else if (presc_cnt >= prescaler) begin
          presc_cnt <= 32'h0;
          value     <= value - 32'h1;
        end else begin
          presc_cnt <= presc_cnt + 32'h1;
        end
      end

      // Bus writes win over counting
      if (wr && req.address == TMR_CTRL) begin
        if (req.wdata[1]) begin
          running <= 1'b0;
        end else if (req.wdata[0]) begin
          running   <= 1'b1;
          presc_cnt <= 32'h0;
        end
      end
      if (wr && req.address == TMR_PRESCALER) begin
        prescaler <= req.wdata;
      end
      if (wr && req.address == TMR_VALUE) begin
        value <= req.wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req.cs) begin
      case (req.address)
        TMR_STATUS:    rdata_reg <= {31'h0, running};
        TMR_PRESCALER: rdata_reg <= prescaler;
        TMR_VALUE:     rdata_reg <= value;
        default:       rdata_reg <= 32'h0;
      endcase
    end
  end

  assign rsp = '{ready: ready_reg, rdata: rdata_reg};

endmodule

// File: hw/sys_ctrl.sv
`timescale 1ns/1ns

module sys_ctrl import soc_pkg::*; (
  input  logic                     clk,
  input  logic                     reset_n,
  input  core_req_t                req,
  input  mem_req_t                 mem_req,
  output core_rsp_t                rsp,
  output logic                     app_mode,
  output logic [RAM_ADDR_BITS-1:0] addr_key,
  output logic [31:0]              data_key,
  output logic                     force_trap,
  output logic [2:0]               led
);

  logic                     wr;
  logic                     app_mode_reg;
  logic [2:0]               led_reg;
  logic [RAM_ADDR_BITS-1:0] addr_key_reg;
  logic [31:0]              data_key_reg;
  logic [31:0]              rdata_reg;
  logic                     ready_reg;

  assign wr = req.cs && (|req.we);

  // ------------------------------------------------------------------
  // Control registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_mode_reg <= 1'b0;
      led_reg      <= LED_RESET;
      addr_key_reg <= '0;
      data_key_reg <= 32'h0;
      ready_reg    <= 1'b0;
    end else begin
      ready_reg <= req.cs;

      // Only reset leaves the sticky application mode
      if (wr && req.address == CTL_APP_MODE && req.wdata[0]) begin
        app_mode_reg <= 1'b1;
      end
      if (wr && req.address == CTL_LED) begin
        led_reg <= req.wdata[2:0];
      end

      // Keys locked once the application runs
      if (wr && !app_mode_reg && req.address == CTL_ADDR_KEY) begin
        addr_key_reg <= req.wdata[RAM_ADDR_BITS-1:0];
      end
      if (wr && !app_mode_reg && req.address == CTL_DATA_KEY) begin
        data_key_reg <= req.wdata;
      end
    end
  end

  // Keys are write only
  always_ff @(posedge clk) begin
    if (req.cs) begin
      case (req.address)
        CTL_APP_MODE: rdata_reg <= {31'h0, app_mode_reg};
        CTL_LED:      rdata_reg <= {29'h0, led_reg};
        default:      rdata_reg <= 32'h0;
      endcase
    end
  end

  assign rsp      = '{ready: ready_reg, rdata: rdata_reg};
  assign app_mode = app_mode_reg;
  assign addr_key = addr_key_reg;
  assign data_key = data_key_reg;
  assign led      = led_reg;

  // Application code may not run ROM code
  assign force_trap = app_mode_reg && mem_req.valid && mem_req.instr &&
                      (mem_req.addr[31:30] == AREA_ROM);

endmodule

// File: hw/mem_decoder.sv
`timescale 1ns/1ns

module mem_decoder import soc_pkg::*; (
  input  logic                     clk,
  input  logic                     reset_n,
  input  mem_req_t                 mem_req,
  input  logic                     app_mode,
  input  logic [RAM_ADDR_BITS-1:0] addr_key,
  input  logic [31:0]              data_key,
  input  logic                     force_trap,
  input  core_rsp_t                rom_rsp,
  input  core_rsp_t                ram_rsp,
  input  core_rsp_t                fw_rsp,
  input  core_rsp_t                tmr_rsp,
  input  core_rsp_t                ctl_rsp,
  output mem_rsp_t                 mem_rsp,
  output core_req_t                rom_req,
  output core_req_t                ram_req,
  output core_req_t                fw_req,
  output core_req_t                tmr_req,
  output core_req_t                ctl_req
);

  logic [1:0]  area;
  logic [5:0]  core;
  logic [15:0] word_addr;
  logic [31:0] ram_mask;
  logic        pending;
  logic        ready_reg;
  logic        ready_new;
  logic [31:0] rdata_reg;
  logic [31:0] rdata_new;

  assign area      = mem_req.addr[31:30];
  assign core      = mem_req.addr[29:24];
  assign word_addr = mem_req.addr[17:2];

  // Data scramble mask, same on the way in and out
  assign ram_mask = data_key ^ {2{mem_req.addr[15:0]}};

  // Request not yet answered
  assign pending = mem_req.valid && !ready_reg;

  // ------------------------------------------------------------------
  // Decode and response mux
  // ------------------------------------------------------------------
  always_comb begin
    ready_new = 1'b0;
    rdata_new = 32'h0;

    rom_req = '{cs: 1'b0, we: mem_req.wstrb,
                address: 16'(word_addr[ROM_ADDR_BITS-1:0]), wdata: mem_req.wdata};
    ram_req = '{cs: 1'b0, we: mem_req.wstrb,
                address: 16'(word_addr[RAM_ADDR_BITS-1:0] ^ addr_key),
                wdata: mem_req.wdata ^ ram_mask};
    fw_req  = '{cs: 1'b0, we: mem_req.wstrb,
                address: 16'(word_addr[FW_RAM_ADDR_BITS-1:0]), wdata: mem_req.wdata};
    tmr_req = '{cs: 1'b0, we: mem_req.wstrb, address: word_addr, wdata: mem_req.wdata};
    ctl_req = '{cs: 1'b0, we: mem_req.wstrb, address: word_addr, wdata: mem_req.wdata};

    if (pending) begin
      if (force_trap) begin
        rdata_new = ILLEGAL_INSTRUCTION;
        ready_new = 1'b1;
      end else begin
        case (area)
          AREA_ROM: begin
            rom_req.cs = 1'b1;
            rdata_new  = rom_rsp.rdata;
            ready_new  = rom_rsp.ready;
          end
          AREA_RAM: begin
            ram_req.cs = 1'b1;
            rdata_new  = ram_rsp.rdata ^ ram_mask;
            ready_new  = ram_rsp.ready;
          end
          AREA_RESERVED: begin
            ready_new = 1'b1;
          end
          AREA_MMIO: begin
            case (core)
              CORE_TIMER: begin
                tmr_req.cs = 1'b1;
                rdata_new  = tmr_rsp.rdata;
                ready_new  = tmr_rsp.ready;
              end
              CORE_FW_RAM: begin
                // Hidden from application code, answers zero at once
                if (!app_mode) begin
                  fw_req.cs = 1'b1;
                  rdata_new = fw_rsp.rdata;
                  ready_new = fw_rsp.ready;
                end else begin
                  ready_new = 1'b1;
                end
              end
              CORE_SYS_CTRL: begin
                ctl_req.cs = 1'b1;
                rdata_new  = ctl_rsp.rdata;
                ready_new  = ctl_rsp.ready;
              end
              default: begin
                ready_new = 1'b1;
              end
            endcase
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= ready_new;
    end
  end

  always_ff @(posedge clk) begin
    rdata_reg <= rdata_new;
  end

  assign mem_rsp = '{ready: ready_reg, rdata: rdata_reg};

  a_one_cs: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0({rom_req.cs, ram_req.cs, fw_req.cs, tmr_req.cs, ctl_req.cs}));

  // Ready is a single-cycle pulse
  a_ready_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    mem_rsp.ready |=> !mem_rsp.ready);

endmodule

// File: hw/app_soc.sv
`timescale 1ns/1ns

module app_soc import soc_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp,
  output logic [2:0] led,
  output logic     app_mode
);

  core_req_t                rom_req, ram_req, fw_req, tmr_req, ctl_req;
  core_rsp_t                rom_rsp, ram_rsp, fw_rsp, tmr_rsp, ctl_rsp;
  logic [RAM_ADDR_BITS-1:0] addr_key;
  logic [31:0]              data_key;
  logic                     force_trap;

  mem_decoder u_decoder (
    .clk, .reset_n, .mem_req, .mem_rsp,
    .app_mode, .addr_key, .data_key, .force_trap,
    .rom_req, .rom_rsp, .ram_req, .ram_rsp, .fw_req, .fw_rsp,
    .tmr_req, .tmr_rsp, .ctl_req, .ctl_rsp
  );

  boot_rom u_rom (.clk, .reset_n, .req(rom_req), .rsp(rom_rsp));

  // Main RAM, scrambled by the decoder
  sram_bank #(.DEPTH_BITS(RAM_ADDR_BITS)) u_ram (
    .clk, .reset_n, .req(ram_req), .rsp(ram_rsp)
  );

  sram_bank #(.DEPTH_BITS(FW_RAM_ADDR_BITS)) u_fw_ram (
    .clk, .reset_n, .req(fw_req), .rsp(fw_rsp)
  );

  mmio_timer u_timer (.clk, .reset_n, .req(tmr_req), .rsp(tmr_rsp));

  sys_ctrl u_sys_ctrl (
    .clk, .reset_n, .req(ctl_req), .mem_req, .rsp(ctl_rsp),
    .app_mode, .addr_key, .data_key, .force_trap, .led
  );

endmodule

// File: verification/tb_app_soc.sv
`timescale 1ns/1ns

module tb_app_soc import soc_pkg::*; ();

  localparam int          BUS_TIMEOUT = 20;
  localparam int          TIMER_POLLS = 100;
  localparam logic [31:0] LFSR_SEED   = 32'h8392;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  logic        clk;
  logic        reset_n;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  logic [2:0]  led;
  logic        app_mode;
  logic        expect_fast;
  logic [31:0] lfsr;
  logic [31:0] ram_model [int];
  int          fw_q [$];

  app_soc UUT (.clk, .reset_n, .mem_req, .mem_rsp, .led, .app_mode);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // Galois LFSR, one step per bit taken
  task automatic draw_bits(input int width, output logic [31:0] bits);
    bits = 32'h0;
    for (int i = 0; i < width; i++) begin
      bits[i] = lfsr[0];
      lfsr    = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
  endtask

  function automatic logic [31:0] mmio_addr(input logic [5:0] core, input logic [15:0] word);
    return {AREA_MMIO, core, 6'h0, word, 2'b00};
  endfunction

  function automatic logic [31:0] area_addr(input logic [1:0] area, input logic [15:0] word);
    return {area, 12'h0, word, 2'b00};
  endfunction

  // Enabled bytes come from the new word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // One request, held until ready, then one idle cycle follows
  task automatic bus_access(input logic [31:0] a, input logic fetch, input logic [3:0] strb,
                            input logic [31:0] data, input logic fast,
                            output logic [31:0] rdata);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    @(negedge clk);
    expect_fast = fast;
    mem_req     = '{valid: 1'b1, instr: fetch, addr: a, wdata: data, wstrb: strb};
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (mem_rsp.ready) begin
        done = 1'b1;
      end else if (cycles > BUS_TIMEOUT) begin
        fail_run($sformatf("No ready within %0d cycles for address %h", BUS_TIMEOUT, a));
      end
    end
    rdata   = mem_rsp.rdata;
    mem_req = '0;
  endtask

  task automatic bus_write(input logic [31:0] a, input logic [3:0] strb,
                           input logic [31:0] data, input logic fast);
    logic [31:0] unused;
    bus_access(a, 1'b0, strb, data, fast, unused);
  endtask

  task automatic bus_read(input logic [31:0] a, input logic fetch, input logic fast,
                          output logic [31:0] data);
    bus_access(a, fetch, 4'h0, 32'h0, fast, data);
  endtask

  // Response latency, one cycle for immediate answers and two for cores
  a_fast_ready: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(mem_req.valid) && expect_fast |=> mem_rsp.ready)
    else fail_run($sformatf("Ready did not come one cycle after valid at %0t ns", $time));

  a_core_ready: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(mem_req.valid) && !expect_fast |=> !mem_rsp.ready ##1 mem_rsp.ready)
    else fail_run($sformatf("Ready did not come two cycles after valid at %0t ns", $time));

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  initial begin
    logic [31:0] idx;
    logic [31:0] old_word;
    logic [31:0] new_word;
    logic [31:0] strb;
    logic [31:0] rd;
    logic [31:0] core;
    int          polls;
    logic        running;

    reset_n     = 1'b0;
    mem_req     = '0;
    expect_fast = 1'b0;
    lfsr        = LFSR_SEED;
    repeat (5) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    check_value("mem_rsp.ready", mem_rsp.ready, 32'h0);
    check_value("app_mode", app_mode, 32'h0);
    check_value("led", led, 32'h0);

    // ROM image
    for (int n = 0; n < 8; n++) begin
      draw_bits(ROM_ADDR_BITS, idx);
      bus_read(area_addr(AREA_ROM, idx[15:0]), 1'b0, 1'b0, rd);
      check_value("rom rdata", rd, ROM_SIGNATURE ^ idx);
    end

    // Keys in firmware mode, then scrambled RAM traffic
    draw_bits(RAM_ADDR_BITS, new_word);
    bus_write(mmio_addr(CORE_SYS_CTRL, CTL_ADDR_KEY), 4'hf, new_word, 1'b0);
    draw_bits(32, new_word);
    bus_write(mmio_addr(CORE_SYS_CTRL, CTL_DATA_KEY), 4'hf, new_word, 1'b0);
    for (int n = 0; n < 8; n++) begin
      draw_bits(RAM_ADDR_BITS, idx);
      draw_bits(32, old_word);
      draw_bits(32, new_word);
      draw_bits(4, strb);
      bus_write(area_addr(AREA_RAM, idx[15:0]), 4'hf, old_word, 1'b0);
      bus_write(area_addr(AREA_RAM, idx[15:0]), strb[3:0], new_word, 1'b0);
      ram_model[int'(idx)] = merge_bytes(old_word, new_word, strb[3:0]);
      bus_read(area_addr(AREA_RAM, idx[15:0]), 1'b0, 1'b0, rd);
      check_value("ram rdata", rd, ram_model[int'(idx)]);
    end

    // Firmware RAM while still reachable
    for (int n = 0; n < 4; n++) begin
      draw_bits(FW_RAM_ADDR_BITS, idx);
      draw_bits(32, new_word);
      bus_write(mmio_addr(CORE_FW_RAM, idx[15:0]), 4'hf, new_word, 1'b0);
      bus_read(mmio_addr(CORE_FW_RAM, idx[15:0]), 1'b0, 1'b0, rd);
      check_value("fw ram rdata", rd, new_word);
      fw_q.push_back(int'(idx));
    end

    // Reserved area and unmapped MMIO cores
    for (int n = 0; n < 4; n++) begin
      draw_bits(30, idx);
      bus_write({AREA_RESERVED, idx[29:0]}, 4'hf, idx, 1'b1);
      bus_read({AREA_RESERVED, idx[29:0]}, 1'b0, 1'b1, rd);
      check_value("reserved rdata", rd, 32'h0);
      draw_bits(6, core);
      if (core[5:0] == CORE_TIMER || core[5:0] == CORE_FW_RAM ||
          core[5:0] == CORE_SYS_CTRL) begin
        core = core ^ 32'h2;
      end
      bus_read(mmio_addr(core[5:0], idx[15:0]), 1'b0, 1'b1, rd);
      check_value("unmapped rdata", rd, 32'h0);
    end

    // Timer countdown
    draw_bits(2, new_word);
    bus_write(mmio_addr(CORE_TIMER, TMR_PRESCALER), 4'hf, new_word, 1'b0);
    draw_bits(3, new_word);
    bus_write(mmio_addr(CORE_TIMER, TMR_VALUE), 4'hf, new_word + 32'h2, 1'b0);
    bus_write(mmio_addr(CORE_TIMER, TMR_CTRL), 4'hf, 32'h1, 1'b0);
    running = 1'b1;
    polls   = 0;
    while (running) begin
      bus_read(mmio_addr(CORE_TIMER, TMR_STATUS), 1'b0, 1'b0, rd);
      running = rd[0];
      polls++;
      if (running && polls > TIMER_POLLS) begin
        fail_run("Timer still running after the poll limit");
      end
    end
    bus_read(mmio_addr(CORE_TIMER, TMR_VALUE), 1'b0, 1'b0, rd);
    check_value("timer value", rd, 32'h0);

    // Application mode and its locks
    bus_write(mmio_addr(CORE_SYS_CTRL, CTL_APP_MODE), 4'hf, 32'h1, 1'b0);
    check_value("app_mode", app_mode, 32'h1);
    bus_write(mmio_addr(CORE_SYS_CTRL, CTL_APP_MODE), 4'hf, 32'h0, 1'b0);
    bus_read(mmio_addr(CORE_SYS_CTRL, CTL_APP_MODE), 1'b0, 1'b0, rd);
    check_value("app_mode reg", rd, 32'h1);
    draw_bits(3, new_word);
    bus_write(mmio_addr(CORE_SYS_CTRL, CTL_LED), 4'hf, new_word, 1'b0);
    check_value("led", led, new_word);
    bus_read(mmio_addr(CORE_SYS_CTRL, CTL_LED), 1'b0, 1'b0, rd);
    check_value("led reg", rd, new_word);

    // Key writes here must not disturb the RAM contents
    draw_bits(RAM_ADDR_BITS, new_word);
    bus_write(mmio_addr(CORE_SYS_CTRL, CTL_ADDR_KEY), 4'hf, new_word, 1'b0);
    draw_bits(32, new_word);
    bus_write(mmio_addr(CORE_SYS_CTRL, CTL_DATA_KEY), 4'hf, new_word, 1'b0);
    foreach (ram_model[i]) begin
      bus_read(area_addr(AREA_RAM, 16'(i)), 1'b0, 1'b0, rd);
      check_value("ram rdata after lock", rd, ram_model[i]);
    end

    draw_bits(ROM_ADDR_BITS, idx);
    bus_read(area_addr(AREA_ROM, idx[15:0]), 1'b1, 1'b1, rd);
    check_value("trapped fetch rdata", rd, ILLEGAL_INSTRUCTION);
    bus_read(area_addr(AREA_ROM, idx[15:0]), 1'b0, 1'b0, rd);
    check_value("rom data read", rd, ROM_SIGNATURE ^ idx);

    foreach (fw_q[i]) begin
      bus_read(mmio_addr(CORE_FW_RAM, 16'(fw_q[i])), 1'b0, 1'b1, rd);
      check_value("guarded fw rdata", rd, 32'h0);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: list.f
hw/soc_pkg.sv
hw/sram_bank.sv
hw/boot_rom.sv
hw/mmio_timer.sv
hw/sys_ctrl.sv
hw/mem_decoder.sv
hw/app_soc.sv
verification/tb_app_soc.sv

// File: Bender.yml
package:
  name: app_soc

sources:
  - files:
      - hw/soc_pkg.sv
      - hw/sram_bank.sv
      - hw/boot_rom.sv
      - hw/mmio_timer.sv
      - hw/sys_ctrl.sv
      - hw/mem_decoder.sv
      - hw/app_soc.sv
  - target: simulation
    files:
      - verification/tb_app_soc.sv
